/* Makefile */
# Verilator build and run of the register file testbench

TOP := tb_rf_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_rf_top.sv */
//////////////////////////////
// Testbench for rf_top with NumRegs 16 and LockstepOffset 2
// Inputs change on the falling edge and gnt_o is read at the rising edge
//////////////////////////////
`timescale 1ns/1ps

module tb_rf_top;

  localparam int Timeout = 20;

  typedef struct packed {
    logic       we;
    logic [4:0] addr;
    logic       rnd;
    logic       bad;
    logic       en;
    logic       wake;
  } entry_t;

  logic        clk_i = 1'b0;
  logic        rst_ni, enable_i, wake_i, req_i, we_i;
  logic [4:0]  addr_i;
  logic [31:0] wdata_i;
  logic [6:0]  wdata_intg_i;
  logic        gnt_o, rvalid_o, err_o, alert_minor_o, alert_major_o, sleep_o;
  logic [31:0] rdata_o;
  logic [6:0]  rdata_intg_o;

  entry_t      table_q [$];
  logic [31:0] model [16];
  int          seed = 32'h9022_e50e;

  rf_top u_rf_top (.*);

  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  // Inverted parity over data bits k, k+7, k+14, ...
  function automatic logic [6:0] check_bits(input logic [31:0] d);
    logic [6:0] c;
    for (int k = 0; k < 7; k++) begin
      c[k] = 1'b1;
      for (int i = k; i < 32; i += 7) begin
        c[k] = c[k] ^ d[i];
      end
    end
    return c;
  endfunction

  task automatic push_entry(input logic we, input logic [4:0] addr, input logic rnd,
                            input logic bad, input logic en, input logic wake);
    table_q.push_back(entry_t'{we: we, addr: addr, rnd: rnd, bad: bad, en: en, wake: wake});
  endtask

  // Starts and returns on a falling edge
  task automatic run_entry(input entry_t e);
    logic [31:0] data;
    logic [6:0]  intg;
    logic [31:0] exp_data;
    logic        in_range;
    logic        granted;
    int          cyc;
    in_range = (e.addr < 5'd16);
    data     = e.rnd ? $random(seed) : (32'h5a00_0000 | 32'(e.addr));
    intg     = e.bad ? (check_bits(data) ^ 7'h15) : check_bits(data);
    exp_data = (!e.we && in_range) ? model[e.addr[3:0]] : 32'h0;
    req_i        = 1'b1;
    we_i         = e.we;
    addr_i       = e.addr;
    wdata_i      = data;
    wdata_intg_i = intg;
    enable_i     = e.en;
    wake_i       = e.wake;
    if (!e.en) begin
      for (cyc = 0; cyc < Timeout; cyc++) begin
        @(posedge clk_i);
        expect_eq("gnt_o", 32'(gnt_o), 32'h0);
        @(negedge clk_i);
        expect_eq("rvalid_o", 32'(rvalid_o), 32'h0);
      end
      req_i = 1'b0;
    end else begin
      granted = 1'b0;
      cyc     = 0;
      while (!granted && cyc < Timeout) begin
        @(posedge clk_i);
        granted = gnt_o;
        cyc++;
      end
      assert (granted) else abort_run("No grant within the timeout window");
      if (e.we && in_range && !e.bad && e.addr != 5'd0) begin
        model[e.addr[3:0]] = data;
      end
      @(negedge clk_i);
      req_i = 1'b0;
      cyc   = 1;
      while (!rvalid_o && cyc < Timeout) begin
        @(negedge clk_i);
        cyc++;
      end
      assert (rvalid_o) else abort_run("No response within the timeout window");
      assert (cyc == 1) else abort_run($sformatf("Response came %0d cycles after grant", cyc));
      expect_eq("err_o", 32'(err_o), 32'(!in_range || (e.we && e.bad)));
      expect_eq("alert_minor_o", 32'(alert_minor_o), 32'(e.we && e.bad));
      expect_eq("rdata_o", rdata_o, exp_data);
      expect_eq("rdata_intg_o", 32'(rdata_intg_o), 32'(check_bits(exp_data)));
    end
    // One idle cycle where wake_i alone decides sleep
    @(negedge clk_i);
    expect_eq("sleep_o", 32'(sleep_o), 32'(!e.wake));
    wake_i = 1'b0;
  endtask

  // Shadow copy must never disagree
  always @(negedge clk_i) begin
    if (rst_ni) begin
      expect_eq("alert_major_o", 32'(alert_major_o), 32'h0);
    end
  end

  initial begin
    rst_ni       = 1'b0;
    enable_i     = 1'b1;
    wake_i       = 1'b0;
    req_i        = 1'b0;
    we_i         = 1'b0;
    addr_i       = 5'd0;
    wdata_i      = 32'h0;
    wdata_intg_i = 7'h7f;
    for (int i = 0; i < 16; i++) begin
      model[i] = 32'h0;
    end
    //         we    addr   rnd   bad   en    wake
    push_entry(1'b0, 5'd0,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd5,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd3,  1'b1, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd3,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd0,  1'b1, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd0,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd7,  1'b1, 1'b1, 1'b1, 1'b0);
    push_entry(1'b0, 5'd7,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd7,  1'b1, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd7,  1'b1, 1'b1, 1'b1, 1'b0);
    push_entry(1'b0, 5'd7,  1'b0, 1'b0, 1'b1, 1'b0);
    // Address 20 aliases x4 in the low bits
    push_entry(1'b1, 5'd20, 1'b1, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd4,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd20, 1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd31, 1'b1, 1'b1, 1'b1, 1'b0);
    push_entry(1'b0, 5'd15, 1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd15, 1'b1, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd15, 1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd3,  1'b0, 1'b0, 1'b0, 1'b0);
    push_entry(1'b0, 5'd3,  1'b0, 1'b0, 1'b1, 1'b1);
    push_entry(1'b1, 5'd9,  1'b0, 1'b0, 1'b1, 1'b1);
    push_entry(1'b0, 5'd9,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b1, 5'd0,  1'b0, 1'b0, 1'b1, 1'b0);
    push_entry(1'b0, 5'd9,  1'b0, 1'b0, 1'b1, 1'b0);
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    expect_eq("rvalid_o", 32'(rvalid_o), 32'h0);
    expect_eq("err_o", 32'(err_o), 32'h0);
    expect_eq("alert_minor_o", 32'(alert_minor_o), 32'h0);
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    repeat (4) @(negedge clk_i);
    $display("Test OK");
    $finish;
  end

endmodule

/* flist.f */
hw/rf_pkg.sv
hw/rf_intg_check.sv
hw/rf_regs.sv
hw/rf_ctrl.sv
hw/rf_delay.sv
hw/rf_lockstep.sv
hw/rf_top.sv
bench/tb_rf_top.sv

/* hw/rf_ctrl.sv */
//////////////////////////////
// Request handshake, no wait states and no back-pressure
// Response flags follow each grant by exactly one cycle
//////////////////////////////
`timescale 1ns/1ps

module rf_ctrl import rf_pkg::*; #(
  parameter int unsigned NumRegs = NumRegsDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 enable_i,
  input  logic                 wake_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic                 intg_ok_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output logic                 err_o,
  output logic                 alert_minor_o,
  output logic                 sleep_o,
  output logic                 rf_we_o,
  output logic                 rf_re_o,
  output logic [AddrWidth-1:0] rf_addr_o
);

  localparam logic [AddrWidth:0] NumRegsVal = (AddrWidth + 1)'(NumRegs);

  logic gnt;
  logic in_range;
  logic intg_fail;
  logic rvalid_q, err_q, alert_minor_q;

  assign gnt       = req_i & enable_i;
  assign in_range  = ({1'b0, addr_i} < NumRegsVal);
  assign intg_fail = we_i & ~intg_ok_i;

  // Writes to x0 are accepted but never reach the array
  assign rf_we_o   = gnt & we_i & in_range & intg_ok_i & (addr_i != '0);
  assign rf_re_o   = gnt & ~we_i & in_range;
  assign rf_addr_o = addr_i;

  //////////////////////////////
  // Response
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q      <= 1'b0;
      err_q         <= 1'b0;
      alert_minor_q <= 1'b0;
    end else begin
      rvalid_q      <= gnt;
      err_q         <= gnt & (~in_range | intg_fail);
      alert_minor_q <= gnt & intg_fail;
    end
  end

  assign gnt_o         = gnt;
  assign rvalid_o      = rvalid_q;
  assign err_o         = err_q;
  assign alert_minor_o = alert_minor_q;

  // Idle when nothing is in flight or asked for
  assign sleep_o = ~rvalid_q & ~req_i & ~wake_i;

endmodule

/* hw/rf_delay.sv */
//////////////////////////////
// Shift chain of Depth stages, clears to zero on reset
// Depth must be 1 or more
//////////////////////////////
`timescale 1ns/1ps

module rf_delay #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  output payload_t data_o
);

  payload_t stage_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

/* hw/rf_intg_check.sv */
//////////////////////////////
// Combinational check of a write word
// Check bit k covers data bits with index mod 7 equal to k
//////////////////////////////
`timescale 1ns/1ps

module rf_intg_check import rf_pkg::*; (
  input  rf_word_t wword_i,
  output logic     intg_ok_o
);

  logic [IntgWidth-1:0] intg_calc;

  // Start from all ones so each bit ends up as inverted parity
  always_comb begin
    intg_calc = '1;
    for (int i = 0; i < DataWidth; i++) begin
      intg_calc[i % IntgWidth] = intg_calc[i % IntgWidth] ^ wword_i.data[i];
    end
  end

  assign intg_ok_o = (intg_calc == wword_i.intg);

endmodule

/* hw/rf_lockstep.sv */
//////////////////////////////
// Shadow control and register file, LockstepOffset cycles behind
// Any output difference raises alert_major_o a cycle later
//////////////////////////////
`timescale 1ns/1ps

module rf_lockstep import rf_pkg::*; #(
  parameter int unsigned NumRegs        = NumRegsDefault,
  parameter int unsigned LockstepOffset = LockstepOffsetDefault
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_in_t  core_in_i,
  input  core_out_t core_out_i,
  output logic      alert_major_o
);

  localparam int unsigned      CntWidth = $clog2(LockstepOffset + 1);
  localparam logic [CntWidth-1:0] WarmDone = CntWidth'(LockstepOffset);

  core_in_t            shadow_in;
  core_out_t           main_out_dly;
  core_out_t           shadow_out;
  logic                shadow_we, shadow_re;
  logic [AddrWidth-1:0] shadow_addr;
  logic [CntWidth-1:0] warm_q;
  logic                compare_en;
  logic                alert_major_q;

  rf_delay #(
    .payload_t(core_in_t),
    .Depth    (LockstepOffset)
  ) u_delay_in (
    .clk_i,
    .rst_ni,
    .data_i(core_in_i),
    .data_o(shadow_in)
  );

  rf_delay #(
    .payload_t(core_out_t),
    .Depth    (LockstepOffset)
  ) u_delay_out (
    .clk_i,
    .rst_ni,
    .data_i(core_out_i),
    .data_o(main_out_dly)
  );

  //////////////////////////////
  // Shadow copy
  //////////////////////////////

  rf_ctrl #(
    .NumRegs(NumRegs)
  ) u_shadow_ctrl (
    .clk_i,
    .rst_ni,
    .enable_i     (shadow_in.enable),
    .wake_i       (shadow_in.wake),
    .req_i        (shadow_in.req),
    .we_i         (shadow_in.we),
    .addr_i       (shadow_in.addr),
    .intg_ok_i    (shadow_in.intg_ok),
    .gnt_o        (shadow_out.gnt),
    .rvalid_o     (shadow_out.rvalid),
    .err_o        (shadow_out.err),
    .alert_minor_o(shadow_out.alert_minor),
    .sleep_o      (shadow_out.sleep),
    .rf_we_o      (shadow_we),
    .rf_re_o      (shadow_re),
    .rf_addr_o    (shadow_addr)
  );

  rf_regs #(
    .NumRegs(NumRegs)
  ) u_shadow_regs (
    .clk_i,
    .rst_ni,
    .we_i   (shadow_we),
    .re_i   (shadow_re),
    .addr_i (shadow_addr),
    .wword_i(shadow_in.wword),
    .rword_o(shadow_out.rword)
  );

  //////////////////////////////
  // Compare
  //////////////////////////////

  // Delayed main outputs are reset zeros until the chain has filled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      warm_q <= '0;
    end else if (warm_q != WarmDone) begin
      warm_q <= warm_q + 1'b1;
    end
  end

  assign compare_en = (warm_q == WarmDone);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_major_q <= 1'b0;
    end else begin
      alert_major_q <= compare_en & (shadow_out != main_out_dly);
    end
  end

  assign alert_major_o = alert_major_q;

endmodule

/* hw/rf_pkg.sv */
//////////////////////////////
// Shared widths and bundle types for the register file
// Check bits are inverted parity, so a zero word carries intg 7f
//////////////////////////////
package rf_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned IntgWidth = 7;
  localparam int unsigned AddrWidth = 5;

  localparam int unsigned NumRegsDefault        = 16;
  localparam int unsigned LockstepOffsetDefault = 2;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [IntgWidth-1:0] intg;
  } rf_word_t;

  localparam rf_word_t WordZero = '{data: 32'h0, intg: 7'h7f};

  // Everything the control and register file see
  typedef struct packed {
    logic                 enable;
    logic                 req;
    logic                 we;
    logic                 wake;
    logic                 intg_ok;
    logic [AddrWidth-1:0] addr;
    rf_word_t             wword;
  } core_in_t;

  // Everything they produce
  typedef struct packed {
    logic     gnt;
    logic     rvalid;
    logic     err;
    logic     alert_minor;
    logic     sleep;
    rf_word_t rword;
  } core_out_t;

endpackage

/* hw/rf_regs.sv */
//////////////////////////////
// Flip-flop register file, one write and one registered read
// x0 is fixed at the zero word and ignores writes
//////////////////////////////
`timescale 1ns/1ps

module rf_regs import rf_pkg::*; #(
  parameter int unsigned NumRegs = NumRegsDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 we_i,
  input  logic                 re_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  rf_word_t             wword_i,
  output rf_word_t             rword_o
);

  localparam int unsigned IdxWidth = $clog2(NumRegs);

  logic [IdxWidth-1:0] idx;
  rf_word_t            regs [NumRegs];
  rf_word_t            rword_q;

  assign idx     = addr_i[IdxWidth-1:0];
  assign regs[0] = WordZero;

  for (genvar i = 1; i < NumRegs; i++) begin : gen_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs[i] <= WordZero;
      end else if (we_i && (idx == IdxWidth'(i))) begin
        regs[i] <= wword_i;
      end
    end
  end

  // Read port, the zero word unless a read is issued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rword_q <= WordZero;
    end else begin
      rword_q <= re_i ? regs[idx] : WordZero;
    end
  end

  assign rword_o = rword_q;

endmodule

/* hw/rf_top.sv */
//////////////////////////////
// Register file with integrity check and lockstep shadow
// Host must accept every response, sleep_o does not gate the clock
//////////////////////////////
`timescale 1ns/1ps

module rf_top import rf_pkg::*; #(
  parameter int unsigned NumRegs        = NumRegsDefault,
  parameter int unsigned LockstepOffset = LockstepOffsetDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 enable_i,
  input  logic                 wake_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [IntgWidth-1:0] wdata_intg_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output logic                 err_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic [IntgWidth-1:0] rdata_intg_o,
  output logic                 alert_minor_o,
  output logic                 alert_major_o,
  output logic                 sleep_o
);

  rf_word_t             wword, rword;
  logic                 intg_ok;
  logic                 rf_we, rf_re;
  logic [AddrWidth-1:0] rf_addr;
  core_in_t             core_in;
  core_out_t            core_out;

  assign wword = '{data: wdata_i, intg: wdata_intg_i};

  rf_intg_check u_intg_check (
    .wword_i  (wword),
    .intg_ok_o(intg_ok)
  );

  rf_ctrl #(
    .NumRegs(NumRegs)
  ) u_ctrl (
    .clk_i,
    .rst_ni,
    .enable_i,
    .wake_i,
    .req_i,
    .we_i,
    .addr_i,
    .intg_ok_i(intg_ok),
    .gnt_o,
    .rvalid_o,
    .err_o,
    .alert_minor_o,
    .sleep_o,
    .rf_we_o  (rf_we),
    .rf_re_o  (rf_re),
    .rf_addr_o(rf_addr)
  );

  rf_regs #(
    .NumRegs(NumRegs)
  ) u_regs (
    .clk_i,
    .rst_ni,
    .we_i   (rf_we),
    .re_i   (rf_re),
    .addr_i (rf_addr),
    .wword_i(wword),
    .rword_o(rword)
  );

  assign rdata_o      = rword.data;
  assign rdata_intg_o = rword.intg;

  // Lockstep bundles
  assign core_in = '{
    enable:  enable_i,
    req:     req_i,
    we:      we_i,
    wake:    wake_i,
    intg_ok: intg_ok,
    addr:    addr_i,
    wword:   wword
  };

  assign core_out = '{
    gnt:         gnt_o,
    rvalid:      rvalid_o,
    err:         err_o,
    alert_minor: alert_minor_o,
    sleep:       sleep_o,
    rword:       rword
  };

  rf_lockstep #(
    .NumRegs       (NumRegs),
    .LockstepOffset(LockstepOffset)
  ) u_lockstep (
    .clk_i,
    .rst_ni,
    .core_in_i    (core_in),
    .core_out_i   (core_out),
    .alert_major_o
  );

endmodule
